// File: mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Opcodes
`define OpRType 6'd0
`define OpBeq   6'd4
`define OpBne   6'd5
`define OpLw    6'd35
`define OpSw    6'd43
`define OpHalt  6'd63

// R-type funct codes
`define FnAdd 6'd32
`define FnSub 6'd34
`define FnAnd 6'd36
`define FnOr  6'd37
`define FnSlt 6'd42

// Widths and depths
`define DataWidth 32
`define ImemDepth 64
`define DmemDepth 64
`define AddrWidth 6

`endif

// File: mipsPkg.sv
`include "mips_defines.svh"

package mipsPkg;

    // ******************************
    // Instruction word views
    // ******************************
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFormatT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFormatT;

    typedef union packed {
        rFormatT rFormat;
        iFormatT iFormat;
    } instrWord;

    // ALUOp classes from the main decoder
    typedef enum logic [1:0] {
        AluAdd    = 2'b00,
        AluSub    = 2'b01,
        AluFunct  = 2'b10,
        AluSubNot = 2'b11
    } aluOpKind;

    typedef enum logic [2:0] {
        FuncAdd,
        FuncSub,
        FuncAnd,
        FuncOr,
        FuncSlt
    } aluFunc;

endpackage

// File: mainControl.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mainControl import mipsPkg::*; (
    input  logic [5:0] opcode,
    output logic       regWrite,
    output logic       regDst,
    output logic       memRead,
    output logic       memWrite,
    output logic       memToReg,
    output logic       branch,
    output logic       branchNot,
    output logic       aluSrc,
    output logic       halt,
    output aluOpKind   aluOp
);

    always_comb begin
        // No-op unless the opcode says otherwise
        regWrite  = 1'b0;
        regDst    = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        memToReg  = 1'b0;
        branch    = 1'b0;
        branchNot = 1'b0;
        aluSrc    = 1'b0;
        halt      = 1'b0;
        aluOp     = AluSubNot;

        case (opcode)
            `OpRType: begin
                regDst   = 1'b1;
                regWrite = 1'b1;
                aluOp    = AluFunct;
            end
            `OpBeq: begin
                branch = 1'b1;
                aluOp  = AluSub;
            end
            `OpBne: begin
                branch    = 1'b1;
                branchNot = 1'b1;
                aluOp     = AluSubNot;
            end
            `OpLw: begin
                memRead  = 1'b1;
                memToReg = 1'b1;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                aluOp    = AluAdd;
            end
            `OpSw: begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = AluAdd;
            end
            `OpHalt: begin
                halt = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: alu.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module alu import mipsPkg::*; (
    input  aluOpKind                aluOp,
    input  logic [5:0]              funct,
    input  logic [`DataWidth-1:0]   a,
    input  logic [`DataWidth-1:0]   b,
    output logic [`DataWidth-1:0]   result,
    output logic                    zero
);

    aluFunc func;

    // ALU control
    always_comb begin
        case (aluOp)
            AluAdd:    func = FuncAdd;
            AluSub:    func = FuncSub;
            AluSubNot: func = FuncSub;
            default: begin
                case (funct)
                    `FnSub:  func = FuncSub;
                    `FnAnd:  func = FuncAnd;
                    `FnOr:   func = FuncOr;
                    `FnSlt:  func = FuncSlt;
                    default: func = FuncAdd;
                endcase
            end
        endcase
    end

    always_comb begin
        result = '0;
        case (func)
            FuncSub: result = a - b;
            FuncAnd: result = a & b;
            FuncOr:  result = a | b;
            FuncSlt: result[0] = $signed(a) < $signed(b);
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: registerFile.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module registerFile (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  writeEnable,
    input  logic [4:0]            readAddrA,
    input  logic [4:0]            readAddrB,
    input  logic [4:0]            writeAddr,
    input  logic [`DataWidth-1:0] writeData,
    output logic [`DataWidth-1:0] readDataA,
    output logic [`DataWidth-1:0] readDataB
);

    logic [`DataWidth-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != 5'd0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // $zero is hardwired
    assign readDataA = (readAddrA == 5'd0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == 5'd0) ? '0 : regs[readAddrB];

endmodule

// File: dataMemory.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module dataMemory (
    input  logic                  clk,
    input  logic                  loadWrite,
    input  logic [`AddrWidth-1:0] loadAddr,
    input  logic [`DataWidth-1:0] loadData,
    input  logic                  coreWrite,
    input  logic [`AddrWidth-1:0] coreAddr,
    input  logic [`DataWidth-1:0] coreData,
    output logic [`DataWidth-1:0] readData
);

    logic [`DataWidth-1:0] mem [`DmemDepth];

    // Load port only writes while the core is idle
    always_ff @(posedge clk) begin
        if (loadWrite) begin
            mem[loadAddr] <= loadData;
        end else if (coreWrite) begin
            mem[coreAddr] <= coreData;
        end
    end

    assign readData = mem[coreAddr];

endmodule

// File: mipsCore.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mipsCore import mipsPkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  loadValid,
    input  logic                  loadToData,
    input  logic [`AddrWidth-1:0] loadAddr,
    input  logic [`DataWidth-1:0] loadData,
    input  logic                  storeReady,
    output logic                  loadReady,
    output logic                  done,
    output logic                  storeValid,
    output logic [`AddrWidth-1:0] storeAddr,
    output logic [`DataWidth-1:0] storeData
);

    logic [`DataWidth-1:0] imem [`ImemDepth];
    logic [`AddrWidth-1:0] pc;
    logic [`AddrWidth-1:0] pcPlusOne;
    logic [`AddrWidth-1:0] pcBranch;
    logic                  running;
    logic                  advance;
    logic                  branchTaken;
    instrWord              instr;

    logic     regWrite, regDst, memRead, memWrite, memToReg;
    logic     branch, branchNot, aluSrc, halt, zero;
    aluOpKind aluOp;

    logic [`DataWidth-1:0] readDataA, readDataB, signExt, aluB;
    logic [`DataWidth-1:0] aluResult, dmemReadData, memData, writeBack;

    // ******************************
    // Load port and sequencing
    // ******************************
    assign loadReady = !running;

    always_ff @(posedge clk) begin
        if (loadValid && loadReady && !loadToData) begin
            imem[loadAddr] <= loadData;
        end
    end

    // Stores hold everything until the handshake
    assign advance = running && (!memWrite || storeReady);

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            done    <= 1'b0;
            pc      <= '0;
        end else if (!running) begin
            if (start) begin
                running <= 1'b1;
                done    <= 1'b0;
                pc      <= '0;
            end
        end else if (advance) begin
            if (halt) begin
                running <= 1'b0;
                done    <= 1'b1;
            end else begin
                pc <= branchTaken ? pcBranch : pcPlusOne;
            end
        end
    end

    // ******************************
    // Datapath
    // ******************************
    assign instr = imem[pc];

    mainControl u_mainControl (
        .opcode    (instr.rFormat.opcode),
        .regWrite  (regWrite),
        .regDst    (regDst),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .memToReg  (memToReg),
        .branch    (branch),
        .branchNot (branchNot),
        .aluSrc    (aluSrc),
        .halt      (halt),
        .aluOp     (aluOp)
    );

    registerFile u_registerFile (
        .clk         (clk),
        .reset       (reset),
        .writeEnable (regWrite && advance),
        .readAddrA   (instr.rFormat.rs),
        .readAddrB   (instr.rFormat.rt),
        .writeAddr   (regDst ? instr.rFormat.rd : instr.rFormat.rt),
        .writeData   (writeBack),
        .readDataA   (readDataA),
        .readDataB   (readDataB)
    );

    assign signExt = {{(`DataWidth - 16){instr.iFormat.imm[15]}}, instr.iFormat.imm};
    assign aluB    = aluSrc ? signExt : readDataB;

    alu u_alu (
        .aluOp  (aluOp),
        .funct  (instr.rFormat.funct),
        .a      (readDataA),
        .b      (aluB),
        .result (aluResult),
        .zero   (zero)
    );

    dataMemory u_dataMemory (
        .clk       (clk),
        .loadWrite (loadValid && loadReady && loadToData),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .coreWrite (storeValid && storeReady),
        .coreAddr  (aluResult[`AddrWidth-1:0]),
        .coreData  (readDataB),
        .readData  (dmemReadData)
    );

    assign memData   = memRead ? dmemReadData : '0;
    assign writeBack = memToReg ? memData : aluResult;

    // bne inverts the zero test
    assign branchTaken = branch && (zero != branchNot);
    assign pcPlusOne   = pc + 1'b1;
    assign pcBranch    = pcPlusOne + instr.iFormat.imm[`AddrWidth-1:0];

    assign storeValid = running && memWrite;
    assign storeAddr  = aluResult[`AddrWidth-1:0];
    assign storeData  = readDataB;

endmodule

// File: clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Two cycles of reset, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: mipsCore_properties.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mipsCore_properties (
    input logic                  clk,
    input logic                  reset,
    input logic                  running,
    input logic                  done,
    input logic                  loadReady,
    input logic                  storeValid,
    input logic                  storeReady,
    input logic [`AddrWidth-1:0] storeAddr,
    input logic [`DataWidth-1:0] storeData
);

    int assertErrors = 0;

    // Stalled store holds still
    storeHeld: assert property (@(posedge clk) disable iff (reset)
        storeValid && !storeReady |=> storeValid && $stable(storeAddr) && $stable(storeData))
        else begin
            assertErrors++;
            $error("store address or data changed while stalled");
        end

    loadStoreExclusive: assert property (@(posedge clk) disable iff (reset)
        !(loadReady && storeValid))
        else begin
            assertErrors++;
            $error("load port ready while a store is pending");
        end

    doneIdle: assert property (@(posedge clk) disable iff (reset) done |-> !running)
        else begin
            assertErrors++;
            $error("done is high while the core is running");
        end

endmodule

bind mipsCore mipsCore_properties u_mipsCoreProperties (
    .clk        (clk),
    .reset      (reset),
    .running    (running),
    .done       (done),
    .loadReady  (loadReady),
    .storeValid (storeValid),
    .storeReady (storeReady),
    .storeAddr  (storeAddr),
    .storeData  (storeData)
);

// File: mipsCore_tb.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mipsCore_tb import mipsPkg::*; ();

    logic                  clk, reset, start, loadValid, loadToData, storeReady;
    logic                  loadReady, done, storeValid;
    logic [`AddrWidth-1:0] loadAddr, storeAddr;
    logic [`DataWidth-1:0] loadData, storeData;

    logic [`DataWidth-1:0] progMem [`ImemDepth];
    logic [`DataWidth-1:0] dataMem [`DmemDepth];
    logic [`DataWidth-1:0] refRegs [32];
    logic [`AddrWidth-1:0] expAddrQ [$];
    logic [`DataWidth-1:0] expDataQ [$];

    int cycleCount = 0;
    int cycleLimit = 100000;
    int addrErrors = 0;
    int dataErrors = 0;
    int storeErrors = 0;
    int flagErrors = 0;

    clockGen u_clockGen (.clk(clk), .reset(reset));

    mipsCore u_mipsCore (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .loadValid  (loadValid),
        .loadToData (loadToData),
        .loadAddr   (loadAddr),
        .loadData   (loadData),
        .storeReady (storeReady),
        .loadReady  (loadReady),
        .done       (done),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData)
    );

    // ******************************
    // Instruction encoding and programs
    // ******************************
    function automatic logic [31:0] rType(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                          logic [5:0] fn);
        instrWord w;
        w.rFormat = '{`OpRType, rs, rt, rd, 5'd0, fn};
        return w;
    endfunction

    function automatic logic [31:0] iType(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        instrWord w;
        w.iFormat = '{op, rs, rt, imm};
        return w;
    endfunction

    task automatic fillImages();
        for (int i = 0; i < `ImemDepth; i++) begin
            progMem[i] = {`OpHalt, 26'd0};
            dataMem[i] = 32'h9E37_79B9 * (i + 1);
        end
    endtask

    // Arithmetic, offsets, $zero, undefined opcode, beq both ways
    task automatic programA();
        fillImages();
        dataMem[0] = 32'd5;
        dataMem[1] = 32'hFFFF_FFFD;
        dataMem[2] = 32'd12;
        dataMem[3] = 32'd4;
        progMem[0] = iType(`OpLw, 0, 10, 16'd3);
        progMem[1] = iType(`OpLw, 10, 1, 16'hFFFC);
        progMem[2] = iType(`OpLw, 10, 2, 16'hFFFD);
        progMem[3] = iType(`OpLw, 0, 3, 16'd2);
        progMem[4] = rType(1, 3, 4, `FnAdd);
        progMem[5] = rType(2, 1, 5, `FnSub);
        progMem[6] = rType(1, 3, 6, `FnAnd);
        progMem[7] = rType(1, 3, 7, `FnOr);
        progMem[8] = rType(2, 1, 8, `FnSlt);
        progMem[9] = rType(1, 2, 9, `FnSlt);
        progMem[10] = iType(6'd17, 1, 2, 16'h1234);
        progMem[11] = iType(`OpLw, 0, 0, 16'd0);
        for (int r = 4; r <= 9; r++) begin
            progMem[8 + r] = iType(`OpSw, 10, 5'(r), 16'(12 + r));
        end
        progMem[18] = iType(`OpSw, 10, 0, 16'd22);
        progMem[19] = iType(`OpBeq, 1, 1, 16'd1);
        progMem[20] = iType(`OpSw, 0, 1, 16'd31);
        progMem[21] = iType(`OpBeq, 1, 2, 16'd5);
        // Fall-through store, r2 untouched by the undefined opcode
        progMem[22] = iType(`OpSw, 0, 2, 16'd32);
        progMem[23] = {`OpHalt, 26'd0};
    endtask

    // Backward bne loop, then a taken beq
    task automatic programB();
        fillImages();
        dataMem[0] = 32'd5;
        dataMem[1] = 32'd1;
        progMem[0] = iType(`OpLw, 0, 1, 16'd0);
        progMem[1] = iType(`OpLw, 0, 2, 16'd1);
        progMem[2] = iType(`OpLw, 0, 3, 16'd4);
        progMem[3] = iType(`OpSw, 1, 1, 16'd40);
        progMem[4] = rType(1, 2, 1, `FnSub);
        progMem[5] = rType(3, 1, 3, `FnAdd);
        progMem[6] = iType(`OpBne, 1, 0, 16'hFFFC);
        progMem[7] = iType(`OpBeq, 1, 0, 16'd1);
        progMem[8] = iType(`OpSw, 0, 1, 16'd60);
        progMem[9] = iType(`OpSw, 0, 3, 16'd50);
    endtask

    // ******************************
    // Instruction-set model
    // ******************************
    function automatic int refRun();
        logic [`DataWidth-1:0] mem [`DmemDepth];
        logic [`DataWidth-1:0] a, b, ea, result;
        logic [`AddrWidth-1:0] pc;
        instrWord              ins;
        int                    count;
        bit                    halted;
        mem = dataMem;
        pc = '0;
        count = 0;
        halted = 1'b0;
        while (!halted && count < 1000) begin
            ins = progMem[pc];
            count++;
            a = refRegs[ins.rFormat.rs];
            b = refRegs[ins.rFormat.rt];
            ea = a + {{16{ins.iFormat.imm[15]}}, ins.iFormat.imm};
            pc = pc + 1'b1;
            case (ins.rFormat.opcode)
                `OpRType: begin
                    case (ins.rFormat.funct)
                        `FnSub:  result = a - b;
                        `FnAnd:  result = a & b;
                        `FnOr:   result = a | b;
                        `FnSlt:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: result = a + b;
                    endcase
                    if (ins.rFormat.rd != 5'd0) refRegs[ins.rFormat.rd] = result;
                end
                `OpLw: if (ins.iFormat.rt != 5'd0) refRegs[ins.iFormat.rt] = mem[ea[5:0]];
                `OpSw: begin
                    mem[ea[5:0]] = b;
                    expAddrQ.push_back(ea[`AddrWidth-1:0]);
                    expDataQ.push_back(b);
                end
                `OpBeq: if (a == b) pc = pc + ins.iFormat.imm[`AddrWidth-1:0];
                `OpBne: if (a != b) pc = pc + ins.iFormat.imm[`AddrWidth-1:0];
                `OpHalt: halted = 1'b1;
                default: begin
                end
            endcase
        end
        return count;
    endfunction

    // ******************************
    // Checks
    // ******************************
    task automatic compareAddr(logic [`AddrWidth-1:0] got, logic [`AddrWidth-1:0] exp);
        if (got !== exp) begin
            addrErrors++;
            $display("ERR %0t store address %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic compareWord(logic [`DataWidth-1:0] got, logic [`DataWidth-1:0] exp);
        if (got !== exp) begin
            dataErrors++;
            $display("ERR %0t store data %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic compareFlag(logic got, logic exp, string what);
        if (got !== exp) begin
            flagErrors++;
            $display("ERR %0t %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic flagStoreCount(string what, int n);
        storeErrors++;
        $display("Store sequence broken at %0t ns: %s (%0d)", $time, what, n);
    endtask

    always @(posedge clk) begin
        if (!reset && storeValid && storeReady) begin
            if (expAddrQ.size() == 0) begin
                flagStoreCount("store the model did not predict, address", storeAddr);
            end else begin
                compareAddr(storeAddr, expAddrQ.pop_front());
                compareWord(storeData, expDataQ.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the core did not finish within %0d cycles", cycleLimit);
            $display("Test failed");
            $finish;
        end
    end

    // ******************************
    // Stimulus
    // ******************************
    task automatic loadWord(logic toData, logic [`AddrWidth-1:0] addr,
                            logic [`DataWidth-1:0] data);
        @(negedge clk);
        loadValid = 1'b1;
        loadToData = toData;
        loadAddr = addr;
        loadData = data;
        @(posedge clk);
        while (!loadReady) @(posedge clk);
    endtask

    task automatic loadAll();
        for (int i = 0; i < `ImemDepth; i++) loadWord(1'b0, i, progMem[i]);
        for (int i = 0; i < `DmemDepth; i++) loadWord(1'b1, i, dataMem[i]);
        @(negedge clk);
        loadValid = 1'b0;
    endtask

    task automatic runProgram(bit randomMode);
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!done) begin
            compareFlag(loadReady, 1'b0, "loadReady while running");
            storeReady = randomMode ? 1'($urandom_range(1, 0)) : 1'b1;
            @(negedge clk);
        end
        storeReady = 1'b1;
        repeat (3) begin
            compareFlag(done, 1'b1, "done after halt");
            compareFlag(loadReady, 1'b1, "loadReady after halt");
            @(negedge clk);
        end
    endtask

    initial begin
        int predicted;
        int total;
        void'($urandom(3));
        start = 1'b0;
        loadValid = 1'b0;
        loadToData = 1'b0;
        loadAddr = '0;
        loadData = '0;
        storeReady = 1'b1;
        for (int r = 0; r < 32; r++) refRegs[r] = '0;

        // Predict all three runs up front to size the timeout
        programA();
        predicted = refRun();
        programA();
        predicted += refRun();
        programB();
        predicted += refRun();
        cycleLimit = 4 * predicted + 3 * (`ImemDepth + `DmemDepth + 8) + 4;

        wait (!reset);
        @(negedge clk);
        compareFlag(loadReady, 1'b1, "loadReady after reset");
        compareFlag(done, 1'b0, "done after reset");
        compareFlag(storeValid, 1'b0, "storeValid after reset");

        programA();
        loadAll();
        runProgram(1'b0);
        programA();
        loadAll();
        runProgram(1'b1);
        programB();
        loadAll();
        runProgram(1'b1);

        if (expAddrQ.size() != 0) flagStoreCount("predicted stores missing", expAddrQ.size());
        total = addrErrors + dataErrors + storeErrors + flagErrors
              + u_mipsCore.u_mipsCoreProperties.assertErrors;
        $display("Errors: address %0d, data %0d, store count %0d, flags %0d, assertions %0d",
                 addrErrors, dataErrors, storeErrors, flagErrors,
                 u_mipsCore.u_mipsCoreProperties.assertErrors);
        if (total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+.
mipsPkg.sv
mainControl.sv
alu.sv
registerFile.sv
dataMemory.sv
mipsCore.sv
clockGen.sv
mipsCore_properties.sv
mipsCore_tb.sv
